/* include/cpu6502_macros.svh */
`ifndef CPU6502_MACROS_SVH
`define CPU6502_MACROS_SVH

// Program counter after reset without a vector fetch
`define CPU_RESET_PC 16'h0200

// Status register where bit 5 always reads 1
`define CPU_P_RESET  8'h20
`define CPU_P_N      7
`define CPU_P_Z      1
`define CPU_P_C      0

// Opcodes of the supported subset
`define OP_LDA_IMM   8'hA9
`define OP_LDA_ABS   8'hAD
`define OP_STA_ABS   8'h8D
`define OP_ADC_IMM   8'h69
`define OP_AND_IMM   8'h29
`define OP_ORA_IMM   8'h09
`define OP_EOR_IMM   8'h49
`define OP_SEC       8'h38
`define OP_CLC       8'h18
`define OP_NOP       8'hEA
`define OP_JMP_ABS   8'h4C

`endif

/* src/cpu6502_pkg.sv */
`default_nettype none

package cpu6502_pkg;

    // Data and address widths
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;

    // Cycle within one instruction
    typedef enum logic [1:0] {
        ST_T0_FETCH   = 2'd0,
        ST_T1_OPERAND = 2'd1,
        ST_T2_ADDR_HI = 2'd2,
        ST_T3_MEMORY  = 2'd3
    } cpu_state_t;

    // ALU function select
    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADC  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_ORA  = 3'd3,
        ALU_EOR  = 3'd4
    } alu_op_t;

    // Source of the address bus
    typedef enum logic {
        ADDR_PC      = 1'b0,
        ADDR_OPERAND = 1'b1
    } addr_sel_t;

endpackage

`default_nettype wire

/* src/cpu6502_ctrl_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface cpu6502_ctrl_if import cpu6502_pkg::*; ();

    // Program counter control
    logic      pc_inc;
    logic      pc_load;

    // Bus control
    addr_sel_t addr_sel;
    logic      rw;             // 1 = read, 0 = write

    // Register and flag loads
    logic      adl_load;
    logic      adh_load;
    logic      a_load;
    alu_op_t   alu_op;
    logic      nz_load;
    logic      c_load;
    logic      c_set;
    logic      c_clr;

    modport decoder (
        output pc_inc, pc_load, addr_sel, rw, adl_load, adh_load,
               a_load, alu_op, nz_load, c_load, c_set, c_clr
    );

    modport counter (input pc_inc, pc_load);

    modport datapath (
        input addr_sel, rw, adl_load, adh_load, a_load, alu_op,
              nz_load, c_load, c_set, c_clr
    );

endinterface

`default_nettype wire

/* src/cpu6502_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu6502_alu import cpu6502_pkg::*; (
    input  wire byte_t   i_a,
    input  wire byte_t   i_b,
    input  wire logic    i_c,
    input  wire alu_op_t i_op,
    output byte_t        o_result,
    output logic         o_c,
    output logic         o_n,
    output logic         o_z
);

    logic [8:0] sum;

    // Binary add only without decimal mode
    assign sum = {1'b0, i_a} + {1'b0, i_b} + {8'd0, i_c};

    always_comb begin
        o_c = i_c;
        case (i_op)
            ALU_PASS: begin
                o_result = i_b;
            end
            ALU_ADC: begin
                o_result = sum[7:0];
                o_c      = sum[8];
            end
            ALU_AND: begin
                o_result = i_a & i_b;
            end
            ALU_ORA: begin
                o_result = i_a | i_b;
            end
            ALU_EOR: begin
                o_result = i_a ^ i_b;
            end
            default: begin
                o_result = i_b;
            end
        endcase
    end

    // Flags from the result
    assign o_n = o_result[7];
    assign o_z = (o_result == 8'd0);

endmodule

`default_nettype wire

/* src/cpu6502_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu6502_macros.svh"

module cpu6502_decoder import cpu6502_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire byte_t     i_data,
    output logic           o_sync,
    cpu6502_ctrl_if.decoder ctrl
);

    cpu_state_t state_q;
    cpu_state_t state_d;
    byte_t      ir_q;

    // Cycle state and instruction register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_T0_FETCH;
            ir_q    <= `OP_NOP;
        end else begin
            state_q <= state_d;
            if (state_q == ST_T0_FETCH) begin
                ir_q <= i_data;
            end
        end
    end

    assign o_sync = (state_q == ST_T0_FETCH);

    // Control lines from state and opcode
    always_comb begin
        state_d       = state_q;
        ctrl.pc_inc   = 1'b0;
        ctrl.pc_load  = 1'b0;
        ctrl.addr_sel = ADDR_PC;
        ctrl.rw       = 1'b1;
        ctrl.adl_load = 1'b0;
        ctrl.adh_load = 1'b0;
        ctrl.a_load   = 1'b0;
        ctrl.alu_op   = ALU_PASS;
        ctrl.nz_load  = 1'b0;
        ctrl.c_load   = 1'b0;
        ctrl.c_set    = 1'b0;
        ctrl.c_clr    = 1'b0;

        case (state_q)
            ST_T0_FETCH: begin
                // Opcode goes into IR at this edge
                ctrl.pc_inc = 1'b1;
                state_d     = ST_T1_OPERAND;
            end

            ST_T1_OPERAND: begin
                state_d = ST_T0_FETCH;
                case (ir_q)
                    `OP_LDA_IMM, `OP_ADC_IMM, `OP_AND_IMM, `OP_ORA_IMM, `OP_EOR_IMM: begin
                        // Operand byte is on the bus now
                        ctrl.a_load  = 1'b1;
                        ctrl.nz_load = 1'b1;
                        ctrl.pc_inc  = 1'b1;
                        case (ir_q)
                            `OP_ADC_IMM: begin
                                ctrl.alu_op = ALU_ADC;
                                ctrl.c_load = 1'b1;
                            end
                            `OP_AND_IMM: ctrl.alu_op = ALU_AND;
                            `OP_ORA_IMM: ctrl.alu_op = ALU_ORA;
                            `OP_EOR_IMM: ctrl.alu_op = ALU_EOR;
                            default:     ctrl.alu_op = ALU_PASS;
                        endcase
                    end
                    `OP_LDA_ABS, `OP_STA_ABS, `OP_JMP_ABS: begin
                        ctrl.adl_load = 1'b1;
                        ctrl.pc_inc   = 1'b1;
                        state_d       = ST_T2_ADDR_HI;
                    end
                    `OP_SEC: ctrl.c_set = 1'b1;
                    `OP_CLC: ctrl.c_clr = 1'b1;
                    `OP_NOP: begin
                        // Dummy read only
                    end
                    default: begin
                        // Unknown opcodes behave as NOP
                    end
                endcase
            end

            ST_T2_ADDR_HI: begin
                if (ir_q == `OP_JMP_ABS) begin
                    // High byte of target is on the bus
                    ctrl.pc_load = 1'b1;
                    state_d      = ST_T0_FETCH;
                end else begin
                    ctrl.adh_load = 1'b1;
                    ctrl.pc_inc   = 1'b1;
                    state_d       = ST_T3_MEMORY;
                end
            end

            ST_T3_MEMORY: begin
                ctrl.addr_sel = ADDR_OPERAND;
                state_d       = ST_T0_FETCH;
                if (ir_q == `OP_STA_ABS) begin
                    ctrl.rw = 1'b0;
                end else if (ir_q == `OP_LDA_ABS) begin
                    ctrl.a_load  = 1'b1;
                    ctrl.nz_load = 1'b1;
                end
            end

            default: begin
                state_d = ST_T0_FETCH;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/cpu6502_pc.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu6502_macros.svh"

module cpu6502_pc import cpu6502_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire byte_t     i_adl,
    input  wire byte_t     i_data,
    cpu6502_ctrl_if.counter ctrl,
    output addr_t          o_pc
);

    addr_t pc_q;
    byte_t pcl_inc;
    byte_t pch_inc;
    logic  pcl_carry;

    // Low byte carries into the high byte
    assign {pcl_carry, pcl_inc} = {1'b0, pc_q[7:0]} + 9'd1;
    assign pch_inc              = pc_q[15:8] + {7'd0, pcl_carry};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= `CPU_RESET_PC;
        end else if (ctrl.pc_load) begin
            // Jump target with the high byte straight from the bus
            pc_q <= {i_data, i_adl};
        end else if (ctrl.pc_inc) begin
            pc_q <= {pch_inc, pcl_inc};
        end
    end

    assign o_pc = pc_q;

endmodule

`default_nettype wire

/* src/cpu6502_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu6502_macros.svh"

module cpu6502_datapath import cpu6502_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       i_rst_n,
    input  wire byte_t      i_data,
    input  wire addr_t      i_pc,
    cpu6502_ctrl_if.datapath ctrl,
    output byte_t           o_adl,
    output addr_t           o_address,
    output logic            o_rw,
    output byte_t           o_data,
    output byte_t           o_a,
    output byte_t           o_p
);

    byte_t a_q;
    byte_t p_q;
    byte_t adl_q;
    byte_t adh_q;

    byte_t alu_result;
    logic  alu_c;
    logic  alu_n;
    logic  alu_z;

    cpu6502_alu u_alu (
        .i_a      (a_q),
        .i_b      (i_data),
        .i_c      (p_q[`CPU_P_C]),
        .i_op     (ctrl.alu_op),
        .o_result (alu_result),
        .o_c      (alu_c),
        .o_n      (alu_n),
        .o_z      (alu_z)
    );

    // Accumulator and status flags
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            a_q <= 8'd0;
            p_q <= `CPU_P_RESET;
        end else begin
            if (ctrl.a_load) begin
                a_q <= alu_result;
            end
            if (ctrl.nz_load) begin
                p_q[`CPU_P_N] <= alu_n;
                p_q[`CPU_P_Z] <= alu_z;
            end
            // SEC and CLC force the carry
            if (ctrl.c_load) begin
                p_q[`CPU_P_C] <= alu_c;
            end else if (ctrl.c_set) begin
                p_q[`CPU_P_C] <= 1'b1;
            end else if (ctrl.c_clr) begin
                p_q[`CPU_P_C] <= 1'b0;
            end
        end
    end

    // Operand address latches
    always_ff @(posedge i_clk) begin
        if (ctrl.adl_load) begin
            adl_q <= i_data;
        end
        if (ctrl.adh_load) begin
            adh_q <= i_data;
        end
    end

    assign o_address = (ctrl.addr_sel == ADDR_OPERAND) ? {adh_q, adl_q} : i_pc;
    assign o_rw      = ctrl.rw;
    assign o_data    = a_q;
    assign o_adl     = adl_q;
    assign o_a       = a_q;
    assign o_p       = p_q;

endmodule

`default_nettype wire

/* src/cpu6502.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu6502 import cpu6502_pkg::*; (
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,

    // 6502 memory bus
    output logic       o_rw,        // 1 = read, 0 = write
    output addr_t      o_address,
    input  wire byte_t i_data,
    output byte_t      o_data,

    output logic       o_sync,      // High in the opcode fetch cycle

    // Debug view of internal registers
    output byte_t      o_debug_a,
    output byte_t      o_debug_p
);

    cpu6502_ctrl_if u_ctrl ();

    addr_t pc;
    byte_t adl;

    cpu6502_decoder u_decoder (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_data),
        .o_sync  (o_sync),
        .ctrl    (u_ctrl.decoder)
    );

    cpu6502_pc u_pc (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_adl   (adl),
        .i_data  (i_data),
        .ctrl    (u_ctrl.counter),
        .o_pc    (pc)
    );

    cpu6502_datapath u_datapath (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_data    (i_data),
        .i_pc      (pc),
        .ctrl      (u_ctrl.datapath),
        .o_adl     (adl),
        .o_address (o_address),
        .o_rw      (o_rw),
        .o_data    (o_data),
        .o_a       (o_debug_a),
        .o_p       (o_debug_p)
    );

endmodule

`default_nettype wire

/* bench/tb_cpu6502.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu6502_macros.svh"

module tb_cpu6502 import cpu6502_pkg::*; ();

    localparam int NUM_INSTR      = 200;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 4 + 50;

    logic  i_clk;
    logic  i_rst_n;
    byte_t i_data;
    logic  o_rw;
    addr_t o_address;
    byte_t o_data;
    logic  o_sync;
    byte_t o_debug_a;
    byte_t o_debug_p;

    byte_t       mem [0:65535];
    byte_t       data_image [0:255];
    logic [31:0] rng_state = 32'd53;
    int          cycle_count = 0;

    // Instruction-level model
    addr_t model_pc;
    byte_t model_a;
    logic  model_n;
    logic  model_z;
    logic  model_c;
    byte_t cur_op;
    addr_t cur_store_addr;
    int    cur_len;
    int    cyc;
    int    instr_count;

    cpu6502 u_dut (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .o_rw      (o_rw),
        .o_address (o_address),
        .i_data    (i_data),
        .o_data    (o_data),
        .o_sync    (o_sync),
        .o_debug_a (o_debug_a),
        .o_debug_p (o_debug_p)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // Memory answers within the cycle and writes at the closing edge
    assign i_data = mem[o_address];

    always @(posedge i_clk) begin
        if (o_rw == 1'b0) begin
            mem[o_address] <= o_data;
        end
    end

    always @(posedge i_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("Timeout after %0d cycles", cycle_count));
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    function automatic byte_t next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[23:16];
    endfunction

    function automatic byte_t pick_opcode(input int idx);
        case (idx)
            0:       return `OP_LDA_IMM;
            1:       return `OP_LDA_ABS;
            2:       return `OP_STA_ABS;
            3:       return `OP_ADC_IMM;
            4:       return `OP_AND_IMM;
            5:       return `OP_ORA_IMM;
            6:       return `OP_EOR_IMM;
            7:       return `OP_SEC;
            8:       return `OP_CLC;
            9:       return `OP_NOP;
            default: return `OP_JMP_ABS;
        endcase
    endfunction

    function automatic byte_t expected_status();
        byte_t p;
        p = `CPU_P_RESET;
        p[`CPU_P_N] = model_n;
        p[`CPU_P_Z] = model_z;
        p[`CPU_P_C] = model_c;
        return p;
    endfunction

    task automatic build_program();
        addr_t addr;
        addr_t target;
        byte_t op;
        int    gap;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = byte_t'(i[15:8] ^ i[7:0] ^ 8'h5A);
        end
        // Data region for absolute loads and stores
        for (int i = 0; i < 256; i++) begin
            data_image[i] = next_random();
            mem[16'h8000 + i] = data_image[i];
        end
        addr = `CPU_RESET_PC;
        for (int n = 0; n < NUM_INSTR; n++) begin
            op = pick_opcode(int'(next_random()) % 11);
            mem[addr] = op;
            case (op)
                `OP_LDA_ABS, `OP_STA_ABS: begin
                    mem[addr + 16'd1] = next_random();
                    mem[addr + 16'd2] = 8'h80;
                    addr = addr + 16'd3;
                end
                `OP_JMP_ABS: begin
                    gap = int'(next_random()) % 4;
                    target = addr + 16'd3 + 16'(gap);
                    mem[addr + 16'd1] = target[7:0];
                    mem[addr + 16'd2] = target[15:8];
                    for (int g = 0; g < gap; g++) begin
                        mem[addr + 16'd3 + 16'(g)] = next_random();
                    end
                    addr = target;
                end
                `OP_SEC, `OP_CLC, `OP_NOP: addr = addr + 16'd1;
                default: begin
                    mem[addr + 16'd1] = next_random();
                    addr = addr + 16'd2;
                end
            endcase
        end
    endtask

    task automatic execute_model();
        byte_t op1;
        byte_t op2;
        int    total;
        cur_op  = mem[model_pc];
        op1     = mem[model_pc + 16'd1];
        op2     = mem[model_pc + 16'd2];
        cur_len = 2;
        case (cur_op)
            `OP_LDA_IMM: model_a = op1;
            `OP_ADC_IMM: begin
                total   = int'(model_a) + int'(op1) + int'(model_c);
                model_c = (total > 255);
                model_a = byte_t'(total);
            end
            `OP_AND_IMM: model_a = model_a & op1;
            `OP_ORA_IMM: model_a = model_a | op1;
            `OP_EOR_IMM: model_a = model_a ^ op1;
            `OP_SEC:     model_c = 1'b1;
            `OP_CLC:     model_c = 1'b0;
            `OP_NOP:     cur_len = 2;
            `OP_LDA_ABS: begin
                model_a = data_image[op1];
                cur_len = 4;
            end
            `OP_STA_ABS: begin
                data_image[op1] = model_a;
                cur_store_addr  = {op2, op1};
                cur_len         = 4;
            end
            `OP_JMP_ABS: cur_len = 3;
            default: stop_with_error("Program holds an opcode outside the supported set");
        endcase
        if (cur_op inside {`OP_LDA_IMM, `OP_ADC_IMM, `OP_AND_IMM, `OP_ORA_IMM,
                           `OP_EOR_IMM, `OP_LDA_ABS}) begin
            model_n = model_a[7];
            model_z = (model_a == 8'd0);
        end
        if (cur_op == `OP_JMP_ABS) begin
            model_pc = {op2, op1};
        end else if (cur_len == 4) begin
            model_pc = model_pc + 16'd3;
        end else if (cur_op inside {`OP_SEC, `OP_CLC, `OP_NOP}) begin
            model_pc = model_pc + 16'd1;
        end else begin
            model_pc = model_pc + 16'd2;
        end
    endtask

    task automatic check_cycle();
        logic write_expected;
        if (o_sync) begin
            if (instr_count > 0) begin
                assert (cyc == cur_len) else stop_with_error($sformatf(
                    "Opcode %h took %0d cycles instead of %0d", cur_op, cyc, cur_len));
            end
            assert (o_address == model_pc) else stop_with_error($sformatf(
                "FAILED o_address: got %h expected %h", o_address, model_pc));
            assert (o_debug_a == model_a) else stop_with_error($sformatf(
                "FAILED o_debug_a: got %h expected %h", o_debug_a, model_a));
            assert (o_debug_p == expected_status()) else stop_with_error($sformatf(
                "FAILED o_debug_p: got %h expected %h", o_debug_p, expected_status()));
            if (instr_count < NUM_INSTR) begin
                execute_model();
            end
            instr_count++;
            cyc = 0;
        end else begin
            assert (cyc < cur_len) else stop_with_error("No opcode fetch after the instruction");
        end
        cyc++;
        // Write only in the last cycle of a store
        write_expected = (cur_op == `OP_STA_ABS) && (cyc == 4);
        assert (o_rw == !write_expected) else stop_with_error($sformatf(
            "FAILED o_rw: got %h expected %h", o_rw, !write_expected));
        if (write_expected) begin
            assert (o_address == cur_store_addr) else stop_with_error($sformatf(
                "FAILED o_address: got %h expected %h", o_address, cur_store_addr));
            assert (o_data == model_a) else stop_with_error($sformatf(
                "FAILED o_data: got %h expected %h", o_data, model_a));
        end
    endtask

    initial begin
        i_rst_n        = 1'b0;
        model_pc       = `CPU_RESET_PC;
        model_a        = 8'd0;
        model_n        = 1'b0;
        model_z        = 1'b0;
        model_c        = 1'b0;
        cur_op         = `OP_NOP;
        cur_store_addr = 16'd0;
        cur_len        = 0;
        cyc            = 0;
        instr_count    = 0;
        build_program();
        repeat (2) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        assert (o_sync == 1'b1) else stop_with_error("o_sync is low after reset");
        assert (o_rw == 1'b1) else stop_with_error($sformatf(
            "FAILED o_rw: got %h expected %h", o_rw, 1'b1));
        assert (o_address == `CPU_RESET_PC) else stop_with_error($sformatf(
            "FAILED o_address: got %h expected %h", o_address, `CPU_RESET_PC));
        while (1) begin
            check_cycle();
            if (instr_count > NUM_INSTR) begin
                break;
            end
            @(posedge i_clk);
            #1;
        end
        // Final memory image of the data region
        for (int i = 0; i < 256; i++) begin
            assert (mem[16'h8000 + i] == data_image[i]) else stop_with_error($sformatf(
                "FAILED mem[%h]: got %h expected %h", 16'h8000 + i,
                mem[16'h8000 + i], data_image[i]));
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* cpu6502.f */
+incdir+include
src/cpu6502_pkg.sv
src/cpu6502_ctrl_if.sv
src/cpu6502_alu.sv
src/cpu6502_decoder.sv
src/cpu6502_pc.sv
src/cpu6502_datapath.sv
src/cpu6502.sv
bench/tb_cpu6502.sv
